// ==== source/matmul_pkg.sv ====
package matmul_pkg;

    // ##############################
    // array geometry and data widths
    // ##############################
    localparam int MAT_MUL_SIZE      = 4;
    localparam int DWIDTH            = 8;
    localparam int COL_WIDTH         = MAT_MUL_SIZE * DWIDTH;  // one row or column.
    localparam int IDX_WIDTH         = $clog2(MAT_MUL_SIZE);   // row/column select.
    localparam int AWIDTH            = 16;
    localparam int ADDR_STRIDE_WIDTH = 8;
    localparam int CNT_WIDTH         = 8;
    localparam int SIZE_WIDTH        = 3;                      // holds 1 to 4.

    // ##############################
    // timing and flow control
    // ##############################
    // accumulator register adds a cycle before the results can be latched.
    localparam logic [CNT_WIDTH-1:0] NUM_CYCLES_IN_MAC = 1;

    localparam int CREDIT_WIDTH = 3;
    localparam logic [CREDIT_WIDTH-1:0] CREDIT_INIT = 2;  // consumer buffer depth.

    // controller states.
    typedef enum logic [1:0] {
        S_IDLE,
        S_COMPUTE,
        S_DRAIN,
        S_DONE
    } ctrl_state_t;

endpackage

// ==== source/cycle_counter.sv ====
`timescale 1ns/10ps

// time base for a run, shared by the skew stage and the result latch.
module cycle_counter
    import matmul_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 run_active,
    output logic [CNT_WIDTH-1:0] clk_cnt
);

    always_ff @(posedge clk) begin
        if (reset) begin
            clk_cnt <= '0;
        end else if (!run_active) begin
            clk_cnt <= '0;                    // zero in the first compute cycle.
        end else if (clk_cnt != '1) begin
            clk_cnt <= clk_cnt + 1'b1;        // saturate, never wrap.
        end
    end

endmodule

// ==== source/matmul_ctrl_fsm.sv ====
`timescale 1ns/10ps

module matmul_ctrl_fsm
    import matmul_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic row_latch_en,
    input  logic drain_empty,
    output logic run_active,
    output logic done_mat_mul,
    output logic busy,
    output logic done
);

    ctrl_state_t state;
    ctrl_state_t next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // ##############################
    // next state
    // ##############################
    always_comb begin
        next_state = state;
        unique case (state)
            S_IDLE: begin
                if (start) begin
                    next_state = S_COMPUTE;
                end
            end
            S_COMPUTE: begin
                if (row_latch_en) begin
                    next_state = S_DRAIN;   // all columns captured this cycle.
                end
            end
            S_DRAIN: begin
                if (drain_empty) begin
                    next_state = S_DONE;
                end
            end
            S_DONE: begin
                next_state = S_IDLE;        // one cycle only.
            end
            default: begin
                next_state = S_IDLE;
            end
        endcase
    end

    // counter, skew and array stay live through the drain.
    assign run_active   = (state == S_COMPUTE) || (state == S_DRAIN);
    assign busy         = (state != S_IDLE);
    assign done_mat_mul = (state == S_DONE);  // clears the output chain.
    assign done         = (state == S_DONE);

endmodule

// ==== source/operand_skew.sv ====
`timescale 1ns/10ps

// operand buffers and the diagonal feed into the array edges.
module operand_skew
    import matmul_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  a_wr_en,
    input  logic                  b_wr_en,
    input  logic [IDX_WIDTH-1:0]  wr_index,
    input  logic [COL_WIDTH-1:0]  wr_data,
    input  logic                  wr_allow,
    input  logic                  run_active,
    input  logic [CNT_WIDTH-1:0]  clk_cnt,
    input  logic [SIZE_WIDTH-1:0] mat_size,
    output logic [COL_WIDTH-1:0]  a_edge,
    output logic [COL_WIDTH-1:0]  b_edge
);

    logic [COL_WIDTH-1:0] a_rows [MAT_MUL_SIZE];  // A by rows.
    logic [COL_WIDTH-1:0] b_cols [MAT_MUL_SIZE];  // B by columns.
    logic [CNT_WIDTH-1:0] size_ext;

    assign size_ext = CNT_WIDTH'(mat_size);

    // element cnt-lane of a row or column, zero outside the size square.
    function automatic logic [DWIDTH-1:0] diag(
        input logic [COL_WIDTH-1:0] vec,
        input logic [CNT_WIDTH-1:0] lane,
        input logic [CNT_WIDTH-1:0] cnt,
        input logic [CNT_WIDTH-1:0] size
    );
        logic [CNT_WIDTH-1:0] k;
        k = cnt - lane;
        if ((lane < size) && (cnt >= lane) && (k < size)) begin
            return vec[k[IDX_WIDTH-1:0]*DWIDTH +: DWIDTH];
        end
        return '0;
    endfunction

    // ##############################
    // host writes, idle only
    // ##############################
    always_ff @(posedge clk) begin
        if (wr_allow && a_wr_en) begin
            a_rows[wr_index] <= wr_data;
        end
        if (wr_allow && b_wr_en) begin
            b_cols[wr_index] <= wr_data;
        end
    end

    // ##############################
    // skewed edge registers
    // ##############################
    always_ff @(posedge clk) begin
        if (reset || !run_active) begin
            a_edge <= '0;
            b_edge <= '0;
        end else begin
            for (int i = 0; i < MAT_MUL_SIZE; i++) begin
                a_edge[i*DWIDTH +: DWIDTH] <= diag(a_rows[i], CNT_WIDTH'(i), clk_cnt, size_ext);
                b_edge[i*DWIDTH +: DWIDTH] <= diag(b_cols[i], CNT_WIDTH'(i), clk_cnt, size_ext);
            end
        end
    end

endmodule

// ==== source/pe_array.sv ====
`timescale 1ns/10ps

// 4x4 grid of MAC cells. a moves right, b moves down.
module pe_array
    import matmul_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 run_active,
    input  logic [COL_WIDTH-1:0] a_edge,
    input  logic [COL_WIDTH-1:0] b_edge,
    output logic [DWIDTH-1:0]    matrixC00,
    output logic [DWIDTH-1:0]    matrixC01,
    output logic [DWIDTH-1:0]    matrixC02,
    output logic [DWIDTH-1:0]    matrixC03,
    output logic [DWIDTH-1:0]    matrixC10,
    output logic [DWIDTH-1:0]    matrixC11,
    output logic [DWIDTH-1:0]    matrixC12,
    output logic [DWIDTH-1:0]    matrixC13,
    output logic [DWIDTH-1:0]    matrixC20,
    output logic [DWIDTH-1:0]    matrixC21,
    output logic [DWIDTH-1:0]    matrixC22,
    output logic [DWIDTH-1:0]    matrixC23,
    output logic [DWIDTH-1:0]    matrixC30,
    output logic [DWIDTH-1:0]    matrixC31,
    output logic [DWIDTH-1:0]    matrixC32,
    output logic [DWIDTH-1:0]    matrixC33
);

    logic [DWIDTH-1:0]   a_in [MAT_MUL_SIZE][MAT_MUL_SIZE];
    logic [DWIDTH-1:0]   b_in [MAT_MUL_SIZE][MAT_MUL_SIZE];
    logic [DWIDTH-1:0]   a_q  [MAT_MUL_SIZE][MAT_MUL_SIZE];  // pass to the right.
    logic [DWIDTH-1:0]   b_q  [MAT_MUL_SIZE][MAT_MUL_SIZE];  // pass downward.
    logic [DWIDTH-1:0]   acc  [MAT_MUL_SIZE][MAT_MUL_SIZE];
    logic [2*DWIDTH-1:0] prod [MAT_MUL_SIZE][MAT_MUL_SIZE];

    for (genvar r = 0; r < MAT_MUL_SIZE; r++) begin : g_row
        for (genvar c = 0; c < MAT_MUL_SIZE; c++) begin : g_col

            // left column takes A from the edge, the rest from the neighbour.
            if (c == 0) begin : g_a_edge
                assign a_in[r][c] = a_edge[r*DWIDTH +: DWIDTH];
            end else begin : g_a_pass
                assign a_in[r][c] = a_q[r][c-1];
            end

            if (r == 0) begin : g_b_edge
                assign b_in[r][c] = b_edge[c*DWIDTH +: DWIDTH];
            end else begin : g_b_pass
                assign b_in[r][c] = b_q[r-1][c];
            end

            assign prod[r][c] = a_in[r][c] * b_in[r][c];

            always_ff @(posedge clk) begin
                if (reset || !run_active) begin
                    a_q[r][c] <= '0;
                    b_q[r][c] <= '0;
                    acc[r][c] <= '0;   // clean start for every run.
                end else begin
                    a_q[r][c] <= a_in[r][c];
                    b_q[r][c] <= b_in[r][c];
                    acc[r][c] <= acc[r][c] + prod[r][c][DWIDTH-1:0];  // wraps mod 256.
                end
            end
        end
    end

    assign matrixC00 = acc[0][0];
    assign matrixC01 = acc[0][1];
    assign matrixC02 = acc[0][2];
    assign matrixC03 = acc[0][3];
    assign matrixC10 = acc[1][0];
    assign matrixC11 = acc[1][1];
    assign matrixC12 = acc[1][2];
    assign matrixC13 = acc[1][3];
    assign matrixC20 = acc[2][0];
    assign matrixC21 = acc[2][1];
    assign matrixC22 = acc[2][2];
    assign matrixC23 = acc[2][3];
    assign matrixC30 = acc[3][0];
    assign matrixC31 = acc[3][1];
    assign matrixC32 = acc[3][2];
    assign matrixC33 = acc[3][3];

endmodule

// ==== source/output_logic.sv ====
`timescale 1ns/10ps

module output_logic
    import matmul_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         run_active,
    input  logic                         done_mat_mul,
    input  logic [AWIDTH-1:0]            address_mat_c,
    input  logic [ADDR_STRIDE_WIDTH-1:0] address_stride_c,
    input  logic [SIZE_WIDTH-1:0]        mat_size,
    input  logic [CNT_WIDTH-1:0]         clk_cnt,
    input  logic [DWIDTH-1:0]            matrixC00,
    input  logic [DWIDTH-1:0]            matrixC01,
    input  logic [DWIDTH-1:0]            matrixC02,
    input  logic [DWIDTH-1:0]            matrixC03,
    input  logic [DWIDTH-1:0]            matrixC10,
    input  logic [DWIDTH-1:0]            matrixC11,
    input  logic [DWIDTH-1:0]            matrixC12,
    input  logic [DWIDTH-1:0]            matrixC13,
    input  logic [DWIDTH-1:0]            matrixC20,
    input  logic [DWIDTH-1:0]            matrixC21,
    input  logic [DWIDTH-1:0]            matrixC22,
    input  logic [DWIDTH-1:0]            matrixC23,
    input  logic [DWIDTH-1:0]            matrixC30,
    input  logic [DWIDTH-1:0]            matrixC31,
    input  logic [DWIDTH-1:0]            matrixC32,
    input  logic [DWIDTH-1:0]            matrixC33,
    input  logic                         c_credit,
    output logic [COL_WIDTH-1:0]         c_data,
    output logic [AWIDTH-1:0]            c_addr,
    output logic                         c_valid,
    output logic                         row_latch_en,
    output logic                         drain_empty
);

    logic [COL_WIDTH-1:0]    cols  [MAT_MUL_SIZE];
    logic [COL_WIDTH-1:0]    chain [MAT_MUL_SIZE];  // captured columns, head first.
    logic [CNT_WIDTH-1:0]    size_ext;
    logic [CNT_WIDTH-1:0]    latch_cnt;
    logic [SIZE_WIDTH-1:0]   remaining;
    logic [CREDIT_WIDTH-1:0] credits;
    logic                    send;

    // row r of each column sits at bits r*DWIDTH.
    assign cols[0] = {matrixC30, matrixC20, matrixC10, matrixC00};
    assign cols[1] = {matrixC31, matrixC21, matrixC11, matrixC01};
    assign cols[2] = {matrixC32, matrixC22, matrixC12, matrixC02};
    assign cols[3] = {matrixC33, matrixC23, matrixC13, matrixC03};

    // ##############################
    // latch cycle 3*size - 1 + mac
    // ##############################
    assign size_ext     = CNT_WIDTH'(mat_size);
    assign latch_cnt    = (size_ext << 1) + size_ext - 1'b1 + NUM_CYCLES_IN_MAC;
    assign row_latch_en = run_active && (clk_cnt == latch_cnt);

    assign drain_empty = (remaining == '0);
    assign send        = run_active && !drain_empty && (credits != '0);

    // ##############################
    // beat and credit control
    // ##############################
    always_ff @(posedge clk) begin
        if (reset) begin
            c_valid   <= 1'b0;
            remaining <= '0;
            credits   <= CREDIT_INIT;
        end else begin
            c_valid <= send;
            credits <= credits + CREDIT_WIDTH'(c_credit) - CREDIT_WIDTH'(send);
            if (done_mat_mul) begin
                remaining <= '0;
            end else if (row_latch_en) begin
                remaining <= mat_size;
            end else if (send) begin
                remaining <= remaining - 1'b1;
            end
        end
    end

    // shift chain. data and address hold while stalled.
    always_ff @(posedge clk) begin
        if (row_latch_en) begin
            chain  <= cols;
            c_addr <= address_mat_c - AWIDTH'(address_stride_c);  // first beat adds it back.
        end else if (done_mat_mul) begin
            for (int i = 0; i < MAT_MUL_SIZE; i++) begin
                chain[i] <= '0;
            end
        end else if (send) begin
            c_data <= chain[0];
            c_addr <= c_addr + AWIDTH'(address_stride_c);
            for (int i = 0; i < MAT_MUL_SIZE - 1; i++) begin
                chain[i] <= chain[i+1];
            end
            chain[MAT_MUL_SIZE-1] <= '0;
        end
    end

endmodule

// ==== source/matmul_top.sv ====
`timescale 1ns/10ps

module matmul_top
    import matmul_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         a_wr_en,
    input  logic                         b_wr_en,
    input  logic [IDX_WIDTH-1:0]         wr_index,
    input  logic [COL_WIDTH-1:0]         wr_data,
    input  logic                         start,
    input  logic [SIZE_WIDTH-1:0]        mat_size,
    input  logic [AWIDTH-1:0]            address_mat_c,
    input  logic [ADDR_STRIDE_WIDTH-1:0] address_stride_c,
    output logic                         busy,
    output logic                         done,
    output logic                         c_valid,
    output logic [AWIDTH-1:0]            c_addr,
    output logic [COL_WIDTH-1:0]         c_data,
    input  logic                         c_credit
);

    logic                         run_active;
    logic                         done_mat_mul;
    logic                         row_latch_en;
    logic                         drain_empty;
    logic [CNT_WIDTH-1:0]         clk_cnt;
    logic [COL_WIDTH-1:0]         a_edge;
    logic [COL_WIDTH-1:0]         b_edge;
    logic [SIZE_WIDTH-1:0]        size_q;
    logic [AWIDTH-1:0]            addr_q;
    logic [ADDR_STRIDE_WIDTH-1:0] stride_q;
    logic [DWIDTH-1:0]            c00, c01, c02, c03;
    logic [DWIDTH-1:0]            c10, c11, c12, c13;
    logic [DWIDTH-1:0]            c20, c21, c22, c23;
    logic [DWIDTH-1:0]            c30, c31, c32, c33;

    // run settings, sampled with start and held while busy.
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            size_q   <= mat_size;
            addr_q   <= address_mat_c;
            stride_q <= address_stride_c;
        end
    end

    cycle_counter cycle_counter_i (
        .clk(clk), .reset(reset), .run_active(run_active), .clk_cnt(clk_cnt)
    );

    matmul_ctrl_fsm matmul_ctrl_fsm_i (
        .clk(clk), .reset(reset), .start(start),
        .row_latch_en(row_latch_en), .drain_empty(drain_empty),
        .run_active(run_active), .done_mat_mul(done_mat_mul),
        .busy(busy), .done(done)
    );

    operand_skew operand_skew_i (
        .clk(clk), .reset(reset),
        .a_wr_en(a_wr_en), .b_wr_en(b_wr_en), .wr_index(wr_index), .wr_data(wr_data),
        .wr_allow(!busy),   // buffers are frozen during a run.
        .run_active(run_active), .clk_cnt(clk_cnt), .mat_size(size_q),
        .a_edge(a_edge), .b_edge(b_edge)
    );

    pe_array pe_array_i (
        .clk(clk), .reset(reset), .run_active(run_active),
        .a_edge(a_edge), .b_edge(b_edge),
        .matrixC00(c00), .matrixC01(c01), .matrixC02(c02), .matrixC03(c03),
        .matrixC10(c10), .matrixC11(c11), .matrixC12(c12), .matrixC13(c13),
        .matrixC20(c20), .matrixC21(c21), .matrixC22(c22), .matrixC23(c23),
        .matrixC30(c30), .matrixC31(c31), .matrixC32(c32), .matrixC33(c33)
    );

    output_logic output_logic_i (
        .clk(clk), .reset(reset),
        .run_active(run_active), .done_mat_mul(done_mat_mul),
        .address_mat_c(addr_q), .address_stride_c(stride_q),
        .mat_size(size_q), .clk_cnt(clk_cnt),
        .matrixC00(c00), .matrixC01(c01), .matrixC02(c02), .matrixC03(c03),
        .matrixC10(c10), .matrixC11(c11), .matrixC12(c12), .matrixC13(c13),
        .matrixC20(c20), .matrixC21(c21), .matrixC22(c22), .matrixC23(c23),
        .matrixC30(c30), .matrixC31(c31), .matrixC32(c32), .matrixC33(c33),
        .c_credit(c_credit),
        .c_data(c_data), .c_addr(c_addr), .c_valid(c_valid),
        .row_latch_en(row_latch_en), .drain_empty(drain_empty)
    );

endmodule

// ==== tb/tb_matmul.sv ====
`timescale 1ns/10ps

module tb_matmul
    import matmul_pkg::*;
();

    localparam int RUN_TIMEOUT = 400;

    logic                         clk;
    logic                         reset;
    logic                         a_wr_en;
    logic                         b_wr_en;
    logic [IDX_WIDTH-1:0]         wr_index;
    logic [COL_WIDTH-1:0]         wr_data;
    logic                         start;
    logic [SIZE_WIDTH-1:0]        mat_size;
    logic [AWIDTH-1:0]            address_mat_c;
    logic [ADDR_STRIDE_WIDTH-1:0] address_stride_c;
    logic                         busy;
    logic                         done;
    logic                         c_valid;
    logic [AWIDTH-1:0]            c_addr;
    logic [COL_WIDTH-1:0]         c_data;
    logic                         c_credit;

    int                   seed = 84193;
    logic [DWIDTH-1:0]    a_m [MAT_MUL_SIZE][MAT_MUL_SIZE];  // A[row][k] as the buffers hold it.
    logic [DWIDTH-1:0]    b_m [MAT_MUL_SIZE][MAT_MUL_SIZE];  // B[k][col].
    logic [COL_WIDTH-1:0] exp_col [MAT_MUL_SIZE];
    logic [AWIDTH-1:0]    exp_base;
    logic [AWIDTH-1:0]    exp_stride;
    int                   exp_beats;
    int                   beat_cnt;
    int                   done_cnt;
    int                   tb_credits;
    int                   max_delay;
    int                   pend [$];    // cycles left before each held credit goes back.
    bit                   noise_on;
    bit                   timed_out;
    int                   err_data;
    int                   err_addr;
    int                   err_flow;
    int                   err_ctrl;
    int                   err_timeout;

    matmul_top matmul_top_i (
        .clk(clk), .reset(reset),
        .a_wr_en(a_wr_en), .b_wr_en(b_wr_en), .wr_index(wr_index), .wr_data(wr_data),
        .start(start), .mat_size(mat_size),
        .address_mat_c(address_mat_c), .address_stride_c(address_stride_c),
        .busy(busy), .done(done),
        .c_valid(c_valid), .c_addr(c_addr), .c_data(c_data), .c_credit(c_credit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int pick(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // ##############################
    // reference model
    // ##############################
    function automatic logic [COL_WIDTH-1:0] model_col(input int col, input int size);
        logic [COL_WIDTH-1:0] v;
        logic [DWIDTH-1:0]    sum;
        v = '0;
        for (int r = 0; r < size; r++) begin
            sum = '0;
            for (int k = 0; k < size; k++) begin
                sum = sum + a_m[r][k] * b_m[k][col];  // wraps mod 256.
            end
            v[r*DWIDTH +: DWIDTH] = sum;
        end
        return v;
    endfunction

    // consumer takes one beat into a buffer slot.
    task automatic take_beat();
        logic [AWIDTH-1:0] want_addr;
        if (tb_credits == 0) begin
            err_flow++;
            $display("c_valid seen at %0t while the consumer had no credit left", $time);
        end else begin
            tb_credits--;
        end
        if (beat_cnt >= exp_beats) begin
            err_ctrl++;
            $display("unexpected beat at %0t after %0d of %0d beats", $time, beat_cnt, exp_beats);
        end else begin
            want_addr = exp_base + AWIDTH'(beat_cnt) * exp_stride;
            if (c_data !== exp_col[beat_cnt]) begin
                err_data++;
                $display("Error at %0t: c_data = %h, expected %h (beat %0d)",
                         $time, c_data, exp_col[beat_cnt], beat_cnt);
            end
            if (c_addr !== want_addr) begin
                err_addr++;
                $display("Error at %0t: c_addr = %h, expected %h (beat %0d)",
                         $time, c_addr, want_addr, beat_cnt);
            end
        end
        beat_cnt++;
        pend.push_back(pick(max_delay + 1));
    endtask

    // one clock cycle. outputs are sampled and inputs driven at the falling edge.
    task automatic step();
        int hit;
        @(negedge clk);
        c_credit = 1'b0;
        if (c_valid) begin
            take_beat();
        end
        if (done) begin
            done_cnt++;
        end
        hit = -1;
        for (int i = 0; i < pend.size(); i++) begin
            if (hit < 0 && pend[i] == 0) begin
                hit = i;
            end
        end
        if (hit >= 0) begin
            pend.delete(hit);
            c_credit = 1'b1;                  // one credit back per cycle at most.
            tb_credits++;
        end
        for (int i = 0; i < pend.size(); i++) begin
            if (pend[i] > 0) begin
                pend[i]--;
            end
        end
        // stray writes while busy are ignored by the buffers.
        if (busy) begin
            a_wr_en  = pick(2);
            b_wr_en  = pick(2);
            wr_index = pick(MAT_MUL_SIZE);
            wr_data  = $random(seed);
            noise_on = 1'b1;
        end else if (noise_on) begin
            a_wr_en  = 1'b0;
            b_wr_en  = 1'b0;
            noise_on = 1'b0;
        end
    endtask

    task automatic load_operands();
        logic [COL_WIDTH-1:0] v;
        for (int m = 0; m < 2 * MAT_MUL_SIZE; m++) begin
            v = $random(seed);
            step();
            a_wr_en  = (m < MAT_MUL_SIZE);
            b_wr_en  = (m >= MAT_MUL_SIZE);
            wr_index = IDX_WIDTH'(m % MAT_MUL_SIZE);
            wr_data  = v;
            for (int k = 0; k < MAT_MUL_SIZE; k++) begin
                if (m < MAT_MUL_SIZE) begin
                    a_m[m][k] = v[k*DWIDTH +: DWIDTH];    // row m of A.
                end else begin
                    b_m[k][m-MAT_MUL_SIZE] = v[k*DWIDTH +: DWIDTH];
                end
            end
        end
        step();
        a_wr_en = 1'b0;
        b_wr_en = 1'b0;
    endtask

    // ##############################
    // one complete run
    // ##############################
    task automatic run_once(input int size, input bit reuse, input int delay_max);
        int                           cycles;
        logic [AWIDTH-1:0]            base;
        logic [ADDR_STRIDE_WIDTH-1:0] stride;
        base   = pick(65536);
        stride = pick(256);
        if (!reuse) begin
            load_operands();
        end
        for (int j = 0; j < MAT_MUL_SIZE; j++) begin
            exp_col[j] = (j < size) ? model_col(j, size) : '0;
        end
        exp_base   = base;
        exp_stride = AWIDTH'(stride);
        exp_beats  = size;
        beat_cnt   = 0;
        done_cnt   = 0;
        max_delay  = delay_max;
        step();
        start            = 1'b1;
        mat_size         = size;
        address_mat_c    = base;
        address_stride_c = stride;
        step();
        start            = 1'b0;
        mat_size         = pick(8);           // the top holds what it sampled.
        address_mat_c    = pick(65536);
        address_stride_c = pick(256);
        cycles = 0;
        while (done_cnt == 0 && cycles < RUN_TIMEOUT) begin
            if (!busy) begin
                err_ctrl++;
                $display("Error at %0t: busy = %b, expected 1 until done", $time, busy);
                break;
            end
            step();
            cycles++;
        end
        if (done_cnt == 0) begin
            if (cycles >= RUN_TIMEOUT) begin
                err_timeout++;
                $display("timeout at %0t: no done within %0d cycles of start",
                         $time, RUN_TIMEOUT);
            end
            timed_out = 1'b1;
            return;
        end
        step();
        if (busy !== 1'b0) begin
            err_ctrl++;
            $display("Error at %0t: busy = %b, expected 0 one cycle after done",
                     $time, busy);
        end
        if (done !== 1'b0) begin
            err_ctrl++;
            $display("Error at %0t: done = %b, expected 0 one cycle after done",
                     $time, done);
        end
        if (beat_cnt != exp_beats) begin
            err_ctrl++;
            $display("Error at %0t: beat count = %0d, expected %0d", $time, beat_cnt, exp_beats);
        end
    endtask

    initial begin
        reset            = 1'b1;
        a_wr_en          = 1'b0;
        b_wr_en          = 1'b0;
        wr_index         = '0;
        wr_data          = '0;
        start            = 1'b0;
        mat_size         = SIZE_WIDTH'(MAT_MUL_SIZE);
        address_mat_c    = '0;
        address_stride_c = '0;
        c_credit         = 1'b0;
        tb_credits       = CREDIT_INIT;
        max_delay        = 6;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        // nothing may come out while idle after reset.
        for (int i = 0; i < 10; i++) begin
            step();
        end
        if (busy !== 1'b0) begin
            err_ctrl++;
            $display("Error at %0t: busy = %b, expected 0 before any start", $time, busy);
        end
        if (done_cnt != 0) begin
            err_ctrl++;
            $display("done pulsed %0d times before any start was given", done_cnt);
        end

        // a full size run first and then random sizes with reused operands and slow credits.
        for (int n = 0; n < 12 && !timed_out; n++) begin
            run_once((n == 0) ? MAT_MUL_SIZE : 1 + pick(MAT_MUL_SIZE),
                     (n % 3 == 2), (n % 4 == 3) ? 20 : 6);
        end

        $display("errors: data %0d, addr %0d, credit %0d, control %0d, timeout %0d",
                 err_data, err_addr, err_flow, err_ctrl, err_timeout);
        if (err_data + err_addr + err_flow + err_ctrl + err_timeout == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
source/matmul_pkg.sv
source/cycle_counter.sv
source/matmul_ctrl_fsm.sv
source/operand_skew.sv
source/pe_array.sv
source/output_logic.sv
source/matmul_top.sv
tb/tb_matmul.sv
